// File: blind_pkg.sv
// scalar blinding shared definitions
`default_nettype none

package blind_pkg;

    // --------------------
    // operand sizes
    // --------------------

    // secret scalar, same width as the group order
    localparam int unsigned SCALAR_W = 64;
    // random blinding value
    localparam int unsigned RND_W = 32;
    // one digit through the narrow multiplier
    localparam int unsigned DIGIT_W = 16;
    // scalar + rnd * order always fits here
    localparam int unsigned RESULT_W = 96;

    // --------------------
    // digit counts
    // --------------------

    // four order digits plus one zero guard digit
    localparam int unsigned ORDER_DIG_NUM = 5;
    // two random digits plus one zero guard digit
    localparam int unsigned RND_DIG_NUM = 3;
    // digits of the full schoolbook product
    localparam int unsigned FULL_DIG_NUM = 8;
    // digits actually retired into the result
    localparam int unsigned RES_DIG_NUM = RESULT_W / DIGIT_W;
    // digit index width
    localparam int unsigned IDX_W = 4;
    // three-digit accumulator, enough for one full column
    localparam int unsigned ACC_W = 3 * DIGIT_W;

    // modulus of the group, odd
    localparam logic [SCALAR_W-1:0] GROUP_ORDER = 64'hf3b9_cac2_fc63_2551;

    // --------------------
    // shared structs
    // --------------------

    // request latched on start
    typedef struct packed {
        logic [SCALAR_W-1:0] scalar;
        logic [RND_W-1:0]    rnd;
    } blind_req_t;

    // column and partial product position
    typedef struct packed {
        logic [IDX_W-1:0] product_idx;
        logic [IDX_W-1:0] operand_idx;
    } digit_idx_t;

    // per-cycle commands from the FSM
    typedef struct packed {
        logic clear;
        logic store;
        logic shift;
        logic advance;
    } step_ctrl_t;

endpackage

`default_nettype wire

// File: operand_store.sv
// operand latch and digit select
`timescale 1ns/1ps
`default_nettype none

module operand_store (
    input  wire logic                           clk,
    input  wire logic                           reset_n,
    input  wire logic                           start_i,
    input  wire blind_pkg::blind_req_t          req_i,
    input  wire blind_pkg::digit_idx_t          idx_i,
    output logic [blind_pkg::DIGIT_W-1:0]       order_digit_o,
    output logic [blind_pkg::DIGIT_W-1:0]       rnd_digit_o,
    output logic [blind_pkg::DIGIT_W-1:0]       scalar_digit_o
);

    // zero padded operand copies
    logic [blind_pkg::FULL_DIG_NUM*blind_pkg::DIGIT_W-1:0]  scalar_q;
    logic [blind_pkg::RND_DIG_NUM*blind_pkg::DIGIT_W-1:0]   rnd_q;
    // order constant with its guard digit on top
    logic [blind_pkg::ORDER_DIG_NUM*blind_pkg::DIGIT_W-1:0] order_pad;
    // order digit position for this partial product
    logic [blind_pkg::IDX_W-1:0]                            order_sel;

    // --------------------
    // operand registers
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scalar_q <= '0;
            rnd_q    <= '0;
        end else if (start_i) begin
            // upper digits read as zero
            scalar_q <= {{(blind_pkg::FULL_DIG_NUM*blind_pkg::DIGIT_W
                           - blind_pkg::SCALAR_W){1'b0}}, req_i.scalar};
            rnd_q    <= {{(blind_pkg::RND_DIG_NUM*blind_pkg::DIGIT_W
                           - blind_pkg::RND_W){1'b0}}, req_i.rnd};
        end
    end

    assign order_pad = {{(blind_pkg::ORDER_DIG_NUM*blind_pkg::DIGIT_W
                          - blind_pkg::SCALAR_W){1'b0}}, blind_pkg::GROUP_ORDER};

    // order digit index is column minus operand
    assign order_sel = idx_i.product_idx - idx_i.operand_idx;

    // --------------------
    // digit muxes
    // --------------------

    always_comb begin
        order_digit_o  = '0;
        rnd_digit_o    = '0;
        scalar_digit_o = '0;
        // out of range positions give a zero digit
        if (order_sel < blind_pkg::IDX_W'(blind_pkg::ORDER_DIG_NUM)) begin
            order_digit_o = order_pad[order_sel*blind_pkg::DIGIT_W +: blind_pkg::DIGIT_W];
        end
        if (idx_i.operand_idx < blind_pkg::IDX_W'(blind_pkg::RND_DIG_NUM)) begin
            rnd_digit_o = rnd_q[idx_i.operand_idx*blind_pkg::DIGIT_W +: blind_pkg::DIGIT_W];
        end
        // scalar digit added at retire time
        if (idx_i.product_idx < blind_pkg::IDX_W'(blind_pkg::FULL_DIG_NUM)) begin
            scalar_digit_o =
                scalar_q[idx_i.product_idx*blind_pkg::DIGIT_W +: blind_pkg::DIGIT_W];
        end
    end

endmodule

`default_nettype wire

// File: digit_counter.sv
// schoolbook digit index counter
`timescale 1ns/1ps
`default_nettype none

module digit_counter (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  clear_i,
    input  wire logic                  advance_i,
    input  wire logic                  step_is_shift_i,
    output blind_pkg::digit_idx_t      idx_o,
    output logic                       operand_last_o,
    output logic                       product_last_o
);

    // current column and partial product
    blind_pkg::digit_idx_t       idx_q;
    // next column index
    logic [blind_pkg::IDX_W-1:0] product_next;
    // first operand that keeps the order digit in range
    logic [blind_pkg::IDX_W-1:0] operand_reload;

    // --------------------
    // next column
    // --------------------

    assign product_next = idx_q.product_idx + blind_pkg::IDX_W'(1);

    always_comb begin
        // low columns start at operand zero
        if (product_next < blind_pkg::IDX_W'(blind_pkg::ORDER_DIG_NUM)) begin
            operand_reload = '0;
        end else begin
            // skip partial products above the order guard digit
            operand_reload = product_next
                             - blind_pkg::IDX_W'(blind_pkg::ORDER_DIG_NUM - 1);
        end
    end

    // --------------------
    // index registers
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idx_q <= '0;
        end else if (clear_i) begin
            idx_q <= '0;
        end else if (advance_i) begin
            if (step_is_shift_i) begin
                // column retired, open the next one
                idx_q.product_idx <= product_next;
                idx_q.operand_idx <= operand_reload;
            end else begin
                // next partial product in this column
                idx_q.operand_idx <= idx_q.operand_idx + blind_pkg::IDX_W'(1);
            end
        end
    end

    // --------------------
    // bound flags
    // --------------------

    // column ends at the diagonal or at the last random digit
    assign operand_last_o = (idx_q.operand_idx == idx_q.product_idx)
                          || (idx_q.operand_idx
                              == blind_pkg::IDX_W'(blind_pkg::RND_DIG_NUM - 1));

    // last column that lands in the result
    assign product_last_o =
        (idx_q.product_idx == blind_pkg::IDX_W'(blind_pkg::RES_DIG_NUM - 1));

    assign idx_o = idx_q;

endmodule

`default_nettype wire

// File: blind_ctrl.sv
// blinding sequence FSM
`timescale 1ns/1ps
`default_nettype none

module blind_ctrl (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              start_i,
    input  wire logic              operand_last_i,
    input  wire logic              product_last_i,
    output blind_pkg::step_ctrl_t  ctrl_o,
    output logic                   busy_o,
    output logic                   done_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_accum,
        st_shift,
        st_finish
    } state_e;

    state_e state_q;
    state_e state_d;

    // --------------------
    // state register
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // next state and step commands
    // --------------------

    always_comb begin
        state_d = state_q;
        ctrl_o  = '0;
        case (state_q)
            st_idle: begin
                // accept a request, clear the datapath
                if (start_i) begin
                    ctrl_o.clear = 1'b1;
                    state_d      = st_accum;
                end
            end
            st_accum: begin
                // one partial product per cycle
                ctrl_o.store = 1'b1;
                // hold the index on the last product, the shift moves it
                ctrl_o.advance = !operand_last_i;
                if (operand_last_i) begin
                    state_d = st_shift;
                end
            end
            st_shift: begin
                ctrl_o.shift = 1'b1;
                // counter stays on the final column
                ctrl_o.advance = !product_last_i;
                state_d = product_last_i ? st_finish : st_accum;
            end
            st_finish: begin
                // not busy here, so a new start is taken
                if (start_i) begin
                    ctrl_o.clear = 1'b1;
                    state_d      = st_accum;
                end else begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // busy drops as done rises
    assign busy_o = (state_q == st_accum) || (state_q == st_shift);
    assign done_o = (state_q == st_finish);

endmodule

`default_nettype wire

// File: mac_datapath.sv
// digit multiply accumulate datapath
`timescale 1ns/1ps
`default_nettype none

module mac_datapath (
    input  wire logic                            clk,
    input  wire logic                            reset_n,
    input  wire blind_pkg::step_ctrl_t           ctrl_i,
    input  wire logic [blind_pkg::IDX_W-1:0]     product_idx_i,
    input  wire logic [blind_pkg::DIGIT_W-1:0]   order_digit_i,
    input  wire logic [blind_pkg::DIGIT_W-1:0]   rnd_digit_i,
    input  wire logic [blind_pkg::DIGIT_W-1:0]   scalar_digit_i,
    output logic [blind_pkg::RESULT_W-1:0]       result_o
);

    // one partial product
    logic [2*blind_pkg::DIGIT_W-1:0]                         product;
    // column accumulator and its next value
    logic [blind_pkg::ACC_W-1:0]                             acc_q;
    logic [blind_pkg::ACC_W-1:0]                             acc_sum;
    // carry between retired digits
    logic                                                    carry_q;
    // low accumulator digit + scalar digit + carry
    logic [blind_pkg::DIGIT_W:0]                             digit_sum;
    // retired result digits
    logic [blind_pkg::RES_DIG_NUM-1:0][blind_pkg::DIGIT_W-1:0] result_q;

    // --------------------
    // multiplier and adders
    // --------------------

    // full 32 bit product of two digits
    assign product = {{blind_pkg::DIGIT_W{1'b0}}, order_digit_i}
                   * {{blind_pkg::DIGIT_W{1'b0}}, rnd_digit_i};

    // product fits below the top accumulator digit
    assign acc_sum = acc_q + {{blind_pkg::DIGIT_W{1'b0}}, product};

    // carry chained digit adder
    assign digit_sum = {1'b0, acc_q[blind_pkg::DIGIT_W-1:0]}
                     + {1'b0, scalar_digit_i}
                     + {{blind_pkg::DIGIT_W{1'b0}}, carry_q};

    // --------------------
    // accumulator and carry
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_q   <= '0;
            carry_q <= 1'b0;
        end else if (ctrl_i.clear) begin
            acc_q   <= '0;
            carry_q <= 1'b0;
        end else if (ctrl_i.store) begin
            acc_q <= acc_sum;
        end else if (ctrl_i.shift) begin
            // low digit leaves through the digit adder
            acc_q   <= acc_q >> blind_pkg::DIGIT_W;
            carry_q <= digit_sum[blind_pkg::DIGIT_W];
        end
    end

    // --------------------
    // result digits
    // --------------------

    // kept through clear so the last result stays readable
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_q <= '0;
        end else if (ctrl_i.shift) begin
            for (int k = 0; k < blind_pkg::RES_DIG_NUM; k++) begin
                if (product_idx_i == blind_pkg::IDX_W'(k)) begin
                    result_q[k] <= digit_sum[blind_pkg::DIGIT_W-1:0];
                end
            end
        end
    end

    assign result_o = result_q;

endmodule

`default_nettype wire

// File: scalar_blinding_top.sv
// scalar blinding unit top
`timescale 1ns/1ps
`default_nettype none

module scalar_blinding_top (
    input  wire logic                          clk,
    input  wire logic                          reset_n,
    input  wire logic                          start_i,
    input  wire blind_pkg::blind_req_t         req_i,
    output logic [blind_pkg::RESULT_W-1:0]     result_o,
    output logic                               busy_o,
    output logic                               done_o
);

    // FSM commands
    blind_pkg::step_ctrl_t         step_ctrl;
    // counter position and bounds
    blind_pkg::digit_idx_t         digit_idx;
    logic                          operand_last;
    logic                          product_last;
    // digits for the current step
    logic [blind_pkg::DIGIT_W-1:0] order_digit;
    logic [blind_pkg::DIGIT_W-1:0] rnd_digit;
    logic [blind_pkg::DIGIT_W-1:0] scalar_digit;

    // --------------------
    // control
    // --------------------

    blind_ctrl i_blind_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .operand_last_i (operand_last),
        .product_last_i (product_last),
        .ctrl_o         (step_ctrl),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    digit_counter i_digit_counter (
        .clk             (clk),
        .reset_n         (reset_n),
        .clear_i         (step_ctrl.clear),
        .advance_i       (step_ctrl.advance),
        .step_is_shift_i (step_ctrl.shift),
        .idx_o           (digit_idx),
        .operand_last_o  (operand_last),
        .product_last_o  (product_last)
    );

    // --------------------
    // data
    // --------------------

    // clear pulses exactly on an accepted start
    operand_store i_operand_store (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (step_ctrl.clear),
        .req_i          (req_i),
        .idx_i          (digit_idx),
        .order_digit_o  (order_digit),
        .rnd_digit_o    (rnd_digit),
        .scalar_digit_o (scalar_digit)
    );

    mac_datapath i_mac_datapath (
        .clk            (clk),
        .reset_n        (reset_n),
        .ctrl_i         (step_ctrl),
        .product_idx_i  (digit_idx.product_idx),
        .order_digit_i  (order_digit),
        .rnd_digit_i    (rnd_digit),
        .scalar_digit_i (scalar_digit),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

// File: scalar_blinding_props.sv
// blinding handshake assertions
`timescale 1ns/1ps
`default_nettype none

module scalar_blinding_props (
    input wire logic clk,
    input wire logic reset_n,
    input wire logic start_i,
    input wire logic busy_o,
    input wire logic done_o
);

    // done is a one cycle strobe
    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o) else $error("done_o high for more than one cycle");

    // busy only falls in the done cycle
    busy_fall: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(busy_o) |-> done_o) else $error("busy_o fell without done_o");

    // done only ends a busy run
    done_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> $fell(busy_o)) else $error("done_o without busy_o falling");

    // a start taken in idle never gives done next
    idle_start: assert property (@(posedge clk) disable iff (!reset_n)
        (start_i && !busy_o && !done_o) |=> (busy_o && !done_o))
        else $error("start in idle did not begin a run");

    // --------------------
    // reset behavior
    // --------------------

    reset_idle: assert property (@(posedge clk)
        $rose(reset_n) |-> (!busy_o && !done_o)) else $error("not idle after reset");

    busy_needs_start: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(busy_o) |-> $past(start_i)) else $error("busy_o rose without a start");

endmodule

bind scalar_blinding_top scalar_blinding_props i_scalar_blinding_props (
    .clk     (clk),
    .reset_n (reset_n),
    .start_i (start_i),
    .busy_o  (busy_o),
    .done_o  (done_o)
);

`default_nettype wire

// File: tb_scalar_blinding.sv
// scalar blinding testbench
`timescale 1ns/1ps
`default_nettype none

module tb_scalar_blinding;

    localparam int CLK_HALF_NS    = 4;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_PAIRS   = 50;
    localparam int HOLD_CYCLES    = 5;

    logic                              clk;
    logic                              reset_n;
    logic                              start_i;
    blind_pkg::blind_req_t             req_i;
    logic [blind_pkg::RESULT_W-1:0]    result_o;
    logic                              busy_o;
    logic                              done_o;
    // seed for $random
    integer                            seed;

    scalar_blinding_top i_scalar_blinding_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start_i),
        .req_i    (req_i),
        .result_o (result_o),
        .busy_o   (busy_o),
        .done_o   (done_o)
    );

    // 8 ns clock
    always #(CLK_HALF_NS) clk = ~clk;

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_result(input string name,
                                input logic [blind_pkg::RESULT_W-1:0] expected,
                                input logic [blind_pkg::RESULT_W-1:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // scalar + rnd * order in full width
    function automatic logic [blind_pkg::RESULT_W-1:0] blinded_value(
        input logic [blind_pkg::SCALAR_W-1:0] scalar,
        input logic [blind_pkg::RND_W-1:0]    rnd
    );
        logic [blind_pkg::RESULT_W-1:0] wide_order;
        wide_order = blind_pkg::RESULT_W'(blind_pkg::GROUP_ORDER);
        return blind_pkg::RESULT_W'(scalar) + blind_pkg::RESULT_W'(rnd) * wide_order;
    endfunction

    // --------------------
    // handshake helpers
    // --------------------

    // one cycle strobe, request held until the next one
    task automatic issue_start(input blind_pkg::blind_req_t req);
        @(posedge clk);
        start_i <= 1'b1;
        req_i   <= req;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    // returns at the negedge where done_o is seen
    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done_o) begin
            check_flag("busy_o", 1'b1, busy_o);
            if (cycles == TIMEOUT_CYCLES) begin
                $display("timeout, done_o never pulsed after start");
                $display("Regression failed");
                $fatal(1, "timeout waiting for done_o");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        // busy falls in the done cycle
        check_flag("busy_o", 1'b0, busy_o);
    endtask

    task automatic blind_run(input logic [blind_pkg::SCALAR_W-1:0] scalar,
                             input logic [blind_pkg::RND_W-1:0]    rnd);
        blind_pkg::blind_req_t req;
        req.scalar = scalar;
        req.rnd    = rnd;
        issue_start(req);
        @(negedge clk);
        wait_done();
        check_result("result_o", blinded_value(scalar, rnd), result_o);
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("busy_o", 1'b0, busy_o);
        check_flag("done_o", 1'b0, done_o);
        check_result("result_o", '0, result_o);
    endtask

    task automatic test_corner_values();
        // zero random value leaves the scalar alone
        blind_run(64'h0123_4567_89ab_cdef, 32'h0);
        // zero scalar times one gives the order
        blind_run(64'h0, 32'h1);
        check_result("result_o", blind_pkg::RESULT_W'(blind_pkg::GROUP_ORDER), result_o);
    endtask

    task automatic test_max_carry();
        blind_run(blind_pkg::GROUP_ORDER - 64'd1, 32'hffff_ffff);
    endtask

    task automatic test_random_pairs();
        logic [blind_pkg::SCALAR_W-1:0] scalar;
        logic [blind_pkg::RND_W-1:0]    rnd;
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            scalar = {$random(seed), $random(seed)};
            scalar = scalar % blind_pkg::GROUP_ORDER;
            rnd    = $random(seed);
            blind_run(scalar, rnd);
        end
    endtask

    task automatic test_result_hold();
        logic [blind_pkg::RESULT_W-1:0] held;
        blind_run(64'hdead_beef_0bad_f00d, 32'h1234_5678);
        held = result_o;
        // idle with no start, result must not move
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_flag("done_o", 1'b0, done_o);
            check_flag("busy_o", 1'b0, busy_o);
            check_result("result_o", held, result_o);
        end
    endtask

    task automatic test_back_to_back();
        // each start lands in the cycle after done
        blind_run(64'h1111_2222_3333_4444, 32'hffff_0001);
        blind_run(64'h0000_0000_0000_0001, 32'h8000_0000);
        blind_run(blind_pkg::GROUP_ORDER - 64'd2, 32'h0000_ffff);
        blind_run(64'h7fff_ffff_ffff_ffff, 32'hffff_fffe);
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        clk     = 1'b0;
        reset_n = 1'b0;
        start_i = 1'b0;
        req_i   = '0;
        seed    = 32'h9aaa_841f;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        test_reset_state();
        test_corner_values();
        test_max_carry();
        test_random_pairs();
        test_result_hold();
        test_back_to_back();
        @(negedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
blind_pkg.sv
operand_store.sv
digit_counter.sv
blind_ctrl.sv
mac_datapath.sv
scalar_blinding_top.sv
scalar_blinding_props.sv
tb_scalar_blinding.sv

// File: run.sh
#!/bin/sh
# build and run the scalar blinding regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_scalar_blinding -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
